// File: project.f
+incdir+include
rtl/alu_pkg.sv
rtl/operand_stage.sv
rtl/arith_unit.sv
rtl/bitwise_unit.sv
rtl/alu_core.sv
rtl/alu_writeback.sv
rtl/alu_top.sv
test/tb_alu.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_alu -f project.f \
    -o tb_alu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_alu_sim > sim.log 2>&1 || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: include/alu_ref_model.svh
// Reference model: expected dout and flags per operation, flag-only operations, shadow packing
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// next dout and flags for an operation issued with a nonzero width
function automatic void ref_alu(input alu_op_t op, input width_t wd, input data_t ax,
                                input data_t bx, input data_t prev, input flags_t f,
                                output data_t r, output flags_t nf);
    int          n;
    data_t       m;
    logic [63:0] tw;
    logic [4:0]  hs;
    logic        cin, sub, c, h, v, bit_in, bit_out;
    n   = wd[0] ? 8 : wd[1] ? 16 : 32;
    m   = wd[0] ? 32'h0000_00ff : wd[1] ? 32'h0000_ffff : 32'hffff_ffff;
    r   = prev;
    nf  = f;
    cin = (op == ALU_ADC || op == ALU_SBC) && f[FLAG_C];
    sub = op inside {ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG};
    if (op == ALU_NEG) begin
        bx = ax;    // negate as 0 - op0
        ax = '0;
    end
    case (op)
        ALU_MOVE: r = bx;
        ALU_ADD, ALU_ADC, ALU_INC, ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG: begin
            if (sub) begin
                r = ax - bx - {31'd0, cin};
                c = {32'd0, ax & m} < {32'd0, bx & m} + {63'd0, cin};  // borrow
                h = {1'b0, ax[3:0]} < {1'b0, bx[3:0]} + {4'd0, cin};
                v = (ax[n-1] != bx[n-1]) && (r[n-1] != ax[n-1]);
            end else begin
                r  = ax + bx + {31'd0, cin};
                tw = {32'd0, ax & m} + {32'd0, bx & m} + {63'd0, cin};
                hs = {1'b0, ax[3:0]} + {1'b0, bx[3:0]} + {4'd0, cin};
                c  = tw[n];
                h  = hs[4];
                v  = (ax[n-1] == bx[n-1]) && (r[n-1] != ax[n-1]);
            end
            if (!(op inside {ALU_INC, ALU_DEC}) || wd[0]) begin
                nf[FLAG_S] = r[n-1];
                nf[FLAG_Z] = (r & m) == '0;
                nf[FLAG_H] = h;
                nf[FLAG_V] = v;
                nf[FLAG_N] = sub;
            end
            if (!(op inside {ALU_INC, ALU_DEC})) begin
                nf[FLAG_C] = c;
            end
        end
        ALU_AND, ALU_OR, ALU_XOR: begin
            r = op == ALU_AND ? ax & bx : op == ALU_OR ? ax | bx : ax ^ bx;
            nf = {r[n-1], (r & m) == '0, 1'b0, op == ALU_AND, 1'b0,
                  wd[0] ? ~^r[7:0] : ~^r[15:0], 2'b00};
        end
        ALU_CPL: begin
            r = ~bx;
            nf[FLAG_H] = 1'b1;
            nf[FLAG_N] = 1'b1;
        end
        ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL, ALU_RRC, ALU_RR, ALU_SRA, ALU_SRL: begin
            if (op inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL}) begin
                bit_out = ax[n-1];
                bit_in  = op == ALU_RL ? f[FLAG_C] : op == ALU_RLC ? ax[n-1] : 1'b0;
                r = (prev & ~m) | (((ax << 1) | {31'd0, bit_in}) & m);
            end else begin
                bit_out = ax[0];
                bit_in  = op == ALU_RR ? f[FLAG_C] : op == ALU_RRC ? ax[0] :
                          op == ALU_SRA ? ax[n-1] : 1'b0;
                r = (prev & ~m) | ((ax & m) >> 1) | ({31'd0, bit_in} << (n - 1));
            end
            nf = {r[n-1], (r & m) == '0, 3'b000, wd[0] ? ~^r[7:0] : ~^r[15:0], 1'b0, bit_out};
        end
        default: ;
    endcase
endfunction

// flags after SCF, RCF, CCF, ZCF or EXFF
function automatic flags_t ref_flag_op(input alu_op_t op, input flags_t f, input shadow_t sh);
    flags_t nf;
    nf = f;
    case (op)
        ALU_SCF:  nf = {f[7:6], 3'b000, f[FLAG_V], 2'b01};
        ALU_RCF:  nf = {f[7:6], 3'b000, f[FLAG_V], 2'b00};
        ALU_CCF:  nf = {f[7:1], ~f[FLAG_C]} & 8'hfd;
        ALU_ZCF:  nf = {f[7:1], ~f[FLAG_Z]} & 8'hfd;
        ALU_EXFF: nf = {sh[5], sh[4], 1'b0, sh[3], 1'b0, sh[2], sh[1], sh[0]};
        default: ;
    endcase
    return nf;
endfunction

// six flags in shadow order S Z H V N C
function automatic shadow_t shadow_of(input flags_t f);
    return {f[FLAG_S], f[FLAG_Z], f[FLAG_H], f[FLAG_V], f[FLAG_N], f[FLAG_C]};
endfunction

`endif

// File: test/tb_alu.sv
// Testbench for the ALU top level: clock, reset, random stimulus, compare process and report
`timescale 1ns/100ps

module tb_alu;

    import alu_pkg::*;

    `include "alu_ref_model.svh"

    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 400;
    localparam int MAX_CYCLES   = (RESET_CYCLES + 3 * NUM_OPS) * 5 / 3;  // worst case plus margin
    localparam alu_op_t DATA_OPS [21] = '{ALU_MOVE, ALU_ADD, ALU_ADC, ALU_INC, ALU_SUB,
        ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG, ALU_AND, ALU_OR, ALU_XOR, ALU_CPL, ALU_RLC,
        ALU_RRC, ALU_RL, ALU_RR, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL};
    localparam alu_op_t FLAG_OPS [5] = '{ALU_SCF, ALU_RCF, ALU_CCF, ALU_ZCF, ALU_EXFF};

    logic        clk, rst, cen, sel_imm, flag_we, flag_only;
    data_t       op0, op1, imm, dout, exp_dout;
    width_t      w, alu_we, exp_alu_we;
    alu_op_t     sel;
    flags_t      flags, exp_flags;
    shadow_t     exp_shadow;
    logic        exp_flag_only, exp_fwe_prev;
    logic [31:0] rng = 32'd63189;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       test_name = "reset";

    alu_top dut0 (
        .clk(clk), .rst(rst), .cen(cen), .op0(op0), .op1(op1), .imm(imm),
        .sel_imm(sel_imm), .flag_we(flag_we), .w(w), .sel(sel),
        .dout(dout), .flags(flags), .alu_we(alu_we), .flag_only(flag_only)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic alu_op_t random_data_op();
        int idx;
        idx = int'(next_random() % 21);
        return DATA_OPS[idx];
    endfunction

    function automatic width_t random_width();
        return 3'b001 << (next_random() % 3);   // one-hot byte, word or long
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // one cycle of stimulus, applied just after the rising edge
    task automatic drive_op(input alu_op_t code, input width_t wd, input logic fwe,
                            input logic en);
        @(posedge clk);
        #1;
        sel     = code;
        w       = wd;
        flag_we = fwe;
        cen     = en;
        op0     = next_random();
        op1     = (next_random() % 8 == 0) ? op0 : next_random();  // equal operands now and then
        imm     = next_random() >> (next_random() % 32);
        sel_imm = next_random() % 4 == 0;
    endtask

    // compare process, model state advances on every enabled edge
    initial begin
        alu_op_t s_sel;
        width_t  s_w;
        logic    s_cen, s_fwe;
        data_t   s_op0, s_op2, nxt_dout;
        flags_t  nxt_flags;
        exp_dout      = '0;
        exp_flags     = '0;
        exp_shadow    = '0;
        exp_alu_we    = '0;
        exp_flag_only = 1'b0;
        exp_fwe_prev  = 1'b0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            compare_value({test_name, " dout"}, exp_dout, dout);
            compare_value({test_name, " flags"}, {24'd0, exp_flags}, {24'd0, flags});
            compare_value({test_name, " alu_we"}, {29'd0, exp_alu_we}, {29'd0, alu_we});
            compare_value({test_name, " flag_only"}, {31'd0, exp_flag_only}, {31'd0, flag_only});
            @(posedge clk);
            s_sel = sel;
            s_w   = w;
            s_cen = cen;
            s_fwe = flag_we;
            s_op0 = op0;
            s_op2 = sel_imm ? imm : op1;
            if (s_cen) begin
                if (s_w != '0) begin
                    ref_alu(s_sel, s_w, s_op0, s_op2, exp_dout, exp_flags, nxt_dout, nxt_flags);
                    exp_dout  = nxt_dout;
                    exp_flags = nxt_flags;
                end else if (s_fwe && !exp_fwe_prev) begin
                    nxt_flags = ref_flag_op(s_sel, exp_flags, exp_shadow);
                    if (s_sel == ALU_EXFF) begin
                        exp_shadow = shadow_of(exp_flags);
                    end
                    exp_flags = nxt_flags;
                end
                exp_fwe_prev  = s_fwe;
                exp_alu_we    = s_w;
                exp_flag_only = s_fwe;
            end
        end
    end

    initial begin
        alu_op_t code;
        rst     = 1'b1;
        cen     = 1'b1;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        flag_we = 1'b0;
        w       = '0;
        sel     = ALU_MOVE;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_name = "arith logic shift";
        repeat (200) drive_op(random_data_op(), random_width(), 1'b0, 1'b1);
        test_name = "flag-only";
        repeat (60) begin
            code = FLAG_OPS[int'(next_random() % 5)];
            repeat (3) drive_op(code, 3'b000, 1'b1, 1'b1);     // held strobe acts once
            drive_op(random_data_op(), random_width(), 1'b0, 1'b1);
        end
        test_name = "clock enable";
        repeat (40) begin
            drive_op(random_data_op(), random_width(), next_random() % 2 == 0, 1'b0);
            drive_op(random_data_op(), random_width(), 1'b0, 1'b1);
        end
        drive_op(ALU_MOVE, 3'b000, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/alu_top.sv
// ALU top level: operand stage, core and writeback
`timescale 1ns/100ps

module alu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  alu_pkg::data_t   op0,        // destination
    input  alu_pkg::data_t   op1,        // source
    input  alu_pkg::data_t   imm,        // alternative source
    input  logic             sel_imm,
    input  logic             flag_we,    // flag-only operation strobe
    input  alu_pkg::width_t  w,          // zero means no operation
    input  alu_pkg::alu_op_t sel,
    output alu_pkg::data_t   dout,
    output alu_pkg::flags_t  flags,
    output alu_pkg::width_t  alu_we,
    output logic             flag_only
);

    import alu_pkg::*;

    data_t op2, rslt;
    ext_t  ext_op0, ext_op2;
    logic  nx_s, nx_z, nx_h, nx_v, nx_n, nx_c;

    operand_stage u_operands (
        .op0(op0), .op1(op1), .imm(imm), .sel_imm(sel_imm), .w(w),
        .op2(op2), .ext_op0(ext_op0), .ext_op2(ext_op2)
    );

    alu_core u_core (
        .op0(op0), .op2(op2), .ext_op0(ext_op0), .ext_op2(ext_op2),
        .sel(sel), .w(w),
        .flags(flags), .dout(dout),     // fed back from the registers
        .rslt(rslt),
        .nx_s(nx_s), .nx_z(nx_z), .nx_h(nx_h),
        .nx_v(nx_v), .nx_n(nx_n), .nx_c(nx_c)
    );

    alu_writeback u_writeback (
        .clk(clk), .rst(rst), .cen(cen),
        .sel(sel), .w(w), .flag_we(flag_we), .rslt(rslt),
        .nx_s(nx_s), .nx_z(nx_z), .nx_h(nx_h),
        .nx_v(nx_v), .nx_n(nx_n), .nx_c(nx_c),
        .dout(dout), .flags(flags),
        .alu_we(alu_we), .flag_only(flag_only)
    );

endmodule

// File: rtl/alu_writeback.sv
// ALU writeback: result, flag and shadow registers, flag-only operations, delayed strobes
`timescale 1ns/100ps

module alu_writeback (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  alu_pkg::alu_op_t sel,
    input  alu_pkg::width_t  w,
    input  logic             flag_we,
    input  alu_pkg::data_t   rslt,
    input  logic             nx_s,
    input  logic             nx_z,
    input  logic             nx_h,
    input  logic             nx_v,
    input  logic             nx_n,
    input  logic             nx_c,
    output alu_pkg::data_t   dout,
    output alu_pkg::flags_t  flags,
    output alu_pkg::width_t  alu_we,     // w one enabled edge later
    output logic             flag_only   // flag_we one enabled edge later
);

    import alu_pkg::*;

    logic    sign, zero, halfc, overflow, negative, carry;
    shadow_t fdash, nx_fdash;           // shadow flag set
    shadow_t up_f;                      // next S Z H V N C
    logic    flag_wel;
    logic    flag_upd;

    assign flags = {sign, zero, 1'b0, halfc, 1'b0, overflow, negative, carry};

    // update on any operation or on a rising flag_we only
    assign flag_upd = w != 0 || (flag_we && !flag_wel);

    always_comb begin
        up_f     = {nx_s, nx_z, nx_h, nx_v, nx_n, nx_c};
        nx_fdash = fdash;
        case (sel)
            ALU_SCF:  up_f = {sign, zero, 1'b0, overflow, 1'b0, 1'b1};
            ALU_RCF:  up_f = {sign, zero, 1'b0, overflow, 1'b0, 1'b0};
            ALU_CCF:  up_f = {sign, zero, halfc, overflow, 1'b0, ~carry};
            ALU_ZCF:  up_f = {sign, zero, halfc, overflow, 1'b0, ~zero};
            ALU_EXFF: begin
                up_f     = fdash;
                nx_fdash = {sign, zero, halfc, overflow, negative, carry};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            {sign, zero, halfc, overflow, negative, carry} <= '0;
            fdash     <= '0;
            flag_wel  <= 1'b0;
            alu_we    <= '0;
            flag_only <= 1'b0;
        end else if (cen) begin
            flag_wel  <= flag_we;
            alu_we    <= w;
            flag_only <= flag_we;
            if (w != 0) begin
                dout <= rslt;   // no result write when idle
            end
            if (flag_upd) begin
                {sign, zero, halfc, overflow, negative, carry} <= up_f;
                fdash <= nx_fdash;
            end
        end
    end

endmodule

// File: rtl/alu_core.sv
// ALU core: result selection per operation code and next-flag computation
`timescale 1ns/100ps

module alu_core (
    input  alu_pkg::data_t   op0,
    input  alu_pkg::data_t   op2,
    input  alu_pkg::ext_t    ext_op0,
    input  alu_pkg::ext_t    ext_op2,
    input  alu_pkg::alu_op_t sel,
    input  alu_pkg::width_t  w,
    input  alu_pkg::flags_t  flags,   // current flag register
    input  alu_pkg::data_t   dout,    // current result register
    output alu_pkg::data_t   rslt,
    output logic             nx_s,
    output logic             nx_z,
    output logic             nx_h,
    output logic             nx_v,
    output logic             nx_n,
    output logic             nx_c
);

    import alu_pkg::*;

    data_t      arith_a, arith_b, sum, bw_rslt;
    ext_t       arith_ext_a, arith_ext_b;
    logic       is_neg, arith_sub, arith_cin, half, ext_msb, bw_cout;
    logic [2:0] cout;
    logic       res_s, res_z, res_even, arith_c, arith_v;

    // NEG runs as 0 - op0
    assign is_neg      = sel == ALU_NEG;
    assign arith_a     = is_neg ? '0 : op0;
    assign arith_ext_a = is_neg ? '0 : ext_op0;
    assign arith_b     = is_neg ? op0 : op2;
    assign arith_ext_b = is_neg ? ext_op0 : ext_op2;
    assign arith_sub   = sel inside {ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG};
    assign arith_cin   = (sel == ALU_ADC || sel == ALU_SBC) && flags[FLAG_C];

    arith_unit u_arith (
        .a(arith_a), .b(arith_b), .ext_a(arith_ext_a), .ext_b(arith_ext_b),
        .sub(arith_sub), .cin(arith_cin), .sum(sum), .half(half),
        .cout(cout), .ext_sum_msb(ext_msb)
    );

    bitwise_unit u_bitwise (
        .sel(sel), .w(w), .a(op0), .b(op2), .prev(dout),
        .carry(flags[FLAG_C]), .rslt(bw_rslt), .cout(bw_cout)
    );

    always_comb begin
        case (sel)
            ALU_MOVE: rslt = op2;
            ALU_ADD, ALU_ADC, ALU_INC, ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG:
                rslt = sum;
            ALU_AND, ALU_OR, ALU_XOR, ALU_CPL, ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
            ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL:
                rslt = bw_rslt;
            default: rslt = dout;   // flag-only and unknown codes
        endcase
    end

    // result properties at the active width
    assign res_s    = w[0] ? rslt[7] : w[1] ? rslt[15] : rslt[31];
    assign res_z    = w[0] ? rslt[7:0] == 0 : w[1] ? rslt[15:0] == 0 : rslt == 0;
    assign res_even = w[0] ? ~^rslt[7:0] : ~^rslt[15:0];
    assign arith_c  = w[0] ? cout[0] : w[1] ? cout[1] : cout[2];
    assign arith_v  = ext_msb ^ res_s;

    always_comb begin
        nx_s = flags[FLAG_S];
        nx_z = flags[FLAG_Z];
        nx_h = flags[FLAG_H];
        nx_v = flags[FLAG_V];
        nx_n = flags[FLAG_N];
        nx_c = flags[FLAG_C];
        case (sel)
            ALU_ADD, ALU_ADC, ALU_INC, ALU_SUB, ALU_SBC, ALU_CP, ALU_DEC, ALU_NEG: begin
                if ((sel != ALU_INC && sel != ALU_DEC) || w[0]) begin
                    nx_s = res_s;
                    nx_z = res_z;
                    nx_h = half;
                    nx_v = arith_v;
                    nx_n = arith_sub;
                end
                if (sel != ALU_INC && sel != ALU_DEC) begin
                    nx_c = arith_c;     // INC and DEC keep C
                end
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                nx_s = res_s;
                nx_z = res_z;
                nx_h = sel == ALU_AND;
                nx_v = res_even;
                nx_n = 1'b0;
                nx_c = 1'b0;
            end
            ALU_CPL: begin
                nx_h = 1'b1;
                nx_n = 1'b1;
            end
            ALU_RLC, ALU_RRC, ALU_RL, ALU_RR, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL: begin
                nx_s = res_s;
                nx_z = res_z;
                nx_h = 1'b0;
                nx_v = res_even;
                nx_n = 1'b0;
                nx_c = bw_cout;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/bitwise_unit.sv
// Bitwise unit: logic operations and single-step shifts and rotates at the active width
`timescale 1ns/100ps

module bitwise_unit (
    input  alu_pkg::alu_op_t sel,
    input  alu_pkg::width_t  w,
    input  alu_pkg::data_t   a,       // shifted operand
    input  alu_pkg::data_t   b,
    input  alu_pkg::data_t   prev,    // supplies bits above the width
    input  logic             carry,   // current C flag
    output alu_pkg::data_t   rslt,
    output logic             cout     // bit shifted out
);

    import alu_pkg::*;

    logic msb_a;
    logic shl_in;
    logic shr_in;

    assign msb_a = w[0] ? a[7] : w[1] ? a[15] : a[31];

    // bit entering at the lsb or msb
    assign shl_in = sel == ALU_RL  ? carry :
                    sel == ALU_RLC ? msb_a : 1'b0;
    assign shr_in = sel == ALU_RR  ? carry :
                    sel == ALU_SRA ? msb_a :
                    sel == ALU_RRC ? a[0]  : 1'b0;

    always_comb begin
        rslt = prev;
        cout = carry;
        case (sel)
            ALU_AND: rslt = a & b;
            ALU_OR:  rslt = a | b;
            ALU_XOR: rslt = a ^ b;
            ALU_CPL: rslt = ~b;
            ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL: begin
                if (w[0]) begin
                    {cout, rslt[7:0]} = {a[7:0], shl_in};
                end else if (w[1]) begin
                    {cout, rslt[15:0]} = {a[15:0], shl_in};
                end else begin
                    {cout, rslt} = {a, shl_in};
                end
            end
            ALU_RRC, ALU_RR, ALU_SRA, ALU_SRL: begin
                if (w[0]) begin
                    {rslt[7:0], cout} = {shr_in, a[7:0]};
                end else if (w[1]) begin
                    {rslt[15:0], cout} = {shr_in, a[15:0]};
                end else begin
                    {rslt, cout} = {shr_in, a};
                end
            end
            default: ;  // keeps prev and carry
        endcase
    end

endmodule

// File: rtl/arith_unit.sv
// Arithmetic unit: nibble-chained adder/subtractor with half carry and per-width carries
`timescale 1ns/100ps

module arith_unit (
    input  alu_pkg::data_t a,
    input  alu_pkg::data_t b,
    input  alu_pkg::ext_t  ext_a,
    input  alu_pkg::ext_t  ext_b,
    input  logic           sub,          // high for a - b - cin
    input  logic           cin,          // carry or borrow in
    output alu_pkg::data_t sum,
    output logic           half,         // carry or borrow out of bit 3
    output logic [2:0]     cout,         // out of bits 31, 15, 7
    output logic           ext_sum_msb   // bit 32 of the extended result
);

    import alu_pkg::*;

    data_t      b_eff;
    ext_t       ext_b_eff;
    ext_t       ext_sum;
    logic       c_in;
    logic       c4;
    logic       c8;
    logic       c16;
    logic       c32;
    logic [3:0] s_lo;
    logic [3:0] s_hi;
    logic [7:0] s_byte1;
    logic [15:0] s_upper;

    // subtraction as a + ~b + ~borrow, carries invert to borrows
    assign b_eff     = sub ? ~b : b;
    assign ext_b_eff = sub ? ~ext_b : ext_b;
    assign c_in      = cin ^ sub;

    assign {c4, s_lo}       = {1'b0, a[3:0]}   + {1'b0, b_eff[3:0]}   + {4'd0, c_in};
    assign {c8, s_hi}       = {1'b0, a[7:4]}   + {1'b0, b_eff[7:4]}   + {4'd0, c4};
    assign {c16, s_byte1}   = {1'b0, a[15:8]}  + {1'b0, b_eff[15:8]}  + {8'd0, c8};
    assign {c32, s_upper}   = {1'b0, a[31:16]} + {1'b0, b_eff[31:16]} + {16'd0, c16};

    assign sum = {s_upper, s_byte1, s_hi, s_lo};

    // signed result one bit wider than any width, for overflow
    assign ext_sum     = ext_a + ext_b_eff + {32'd0, c_in};
    assign ext_sum_msb = ext_sum[32];

    assign half = c4 ^ sub;
    assign cout = {c32, c16, c8} ^ {3{sub}};

endmodule

// File: rtl/operand_stage.sv
// Operand stage: second-operand select and width-dependent sign extension
`timescale 1ns/100ps

module operand_stage (
    input  alu_pkg::data_t  op0,       // destination
    input  alu_pkg::data_t  op1,       // source
    input  alu_pkg::data_t  imm,       // alternative source
    input  logic            sel_imm,
    input  alu_pkg::width_t w,
    output alu_pkg::data_t  op2,
    output alu_pkg::ext_t   ext_op0,
    output alu_pkg::ext_t   ext_op2
);

    import alu_pkg::*;

    // extend from the msb of the active width
    function automatic ext_t extend(input data_t x, input width_t wd);
        ext_t e;
        if (wd[0]) begin
            e = {{25{x[7]}}, x[7:0]};
        end else if (wd[1]) begin
            e = {{17{x[15]}}, x[15:0]};
        end else begin
            e = {x[31], x};     // long, also the idle case
        end
        return e;
    endfunction

    assign op2     = sel_imm ? imm : op1;
    assign ext_op0 = extend(op0, w);
    assign ext_op2 = extend(op2, w);

endmodule

// File: rtl/alu_pkg.sv
// ALU package: data widths, operand and flag types, operation codes and flag-bit positions
package alu_pkg;

    typedef logic [31:0] data_t;    // operand or result word
    typedef logic [32:0] ext_t;     // sign-extended operand for overflow
    typedef logic [ 2:0] width_t;   // one-hot: long, word, byte
    typedef logic [ 6:0] alu_op_t;  // operation code
    typedef logic [ 7:0] flags_t;   // S Z 0 H 0 V N C
    typedef logic [ 5:0] shadow_t;  // S Z H V N C

    // arithmetic
    localparam alu_op_t ALU_MOVE = 7'h00;
    localparam alu_op_t ALU_ADD  = 7'h01;
    localparam alu_op_t ALU_ADC  = 7'h02;
    localparam alu_op_t ALU_INC  = 7'h03;
    localparam alu_op_t ALU_SUB  = 7'h04;
    localparam alu_op_t ALU_SBC  = 7'h05;
    localparam alu_op_t ALU_CP   = 7'h06;
    localparam alu_op_t ALU_DEC  = 7'h07;
    localparam alu_op_t ALU_NEG  = 7'h08;

    // logic
    localparam alu_op_t ALU_AND  = 7'h10;
    localparam alu_op_t ALU_OR   = 7'h11;
    localparam alu_op_t ALU_XOR  = 7'h12;
    localparam alu_op_t ALU_CPL  = 7'h13;

    // single-step shifts and rotates
    localparam alu_op_t ALU_RLC  = 7'h20;
    localparam alu_op_t ALU_RRC  = 7'h21;
    localparam alu_op_t ALU_RL   = 7'h22;
    localparam alu_op_t ALU_RR   = 7'h23;
    localparam alu_op_t ALU_SLA  = 7'h24;
    localparam alu_op_t ALU_SRA  = 7'h25;
    localparam alu_op_t ALU_SLL  = 7'h26;
    localparam alu_op_t ALU_SRL  = 7'h27;

    // flag-only
    localparam alu_op_t ALU_SCF  = 7'h30;
    localparam alu_op_t ALU_RCF  = 7'h31;
    localparam alu_op_t ALU_CCF  = 7'h32;
    localparam alu_op_t ALU_ZCF  = 7'h33;
    localparam alu_op_t ALU_EXFF = 7'h34;   // swap with shadow set

    // bit positions inside flags_t
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

endpackage
